// ==== design/rv32_csr_access.sv ====
`timescale 1ns/1ns

`include "rv32_csr_params.svh"

module rv32_csr_access
    import rv32_csr_addr_pkg::*, rv32_csr_ops_pkg::*;
(
    input  logic                           stall,
    input  logic                           flush,
    input  logic                           write,
    input  csr_write_op_e                  write_op,
    input  csr_src_e                       src,
    input  csr_addr_t                      csr,
    input  xlen_t                          rs1_value,
    input  xlen_t                          imm_value,

    input  logic                           mstatus_mie,
    input  logic                           mstatus_mpie,
    input  logic [2:0]                     mie_bits,
    input  logic [2:0]                     mip_bits,
    input  logic [`RV32_XLEN-3:0]          mtvec_base,
    input  logic                           mtvec_mode,
    input  xlen_t                          mscratch,
    input  logic [`RV32_XLEN-3:0]          mepc_word,
    input  logic                           mcause_interrupt,
    input  logic [`RV32_MCAUSE_CODE_W-1:0] mcause_code,
    input  xlen_t                          mtval,

    input  counter_t                       cycle_count,
    input  counter_t                       instret_count,

    output xlen_t                          read_value,
    output xlen_t                          new_value,
    output logic                           write_strobe
);

    xlen_t operand;
    xlen_t mstatus_image;
    xlen_t mcause_image;

    // Spread the three interrupt bits to their mie/mip positions.
    function automatic xlen_t irq_image(input logic [2:0] bits);
        xlen_t img;
        img = '0;
        img[`RV32_IRQ_EXT_BIT]   = bits[2];
        img[`RV32_IRQ_TIMER_BIT] = bits[1];
        img[`RV32_IRQ_SOFT_BIT]  = bits[0];
        return img;
    endfunction

    // Hart runs in machine mode only, so MPP always reads 3.
    always_comb begin
        mstatus_image = '0;
        mstatus_image[`RV32_MSTATUS_MPP_HI:`RV32_MSTATUS_MPP_LO] = 2'b11;
        mstatus_image[`RV32_MSTATUS_MPIE_BIT] = mstatus_mpie;
        mstatus_image[`RV32_MSTATUS_MIE_BIT]  = mstatus_mie;
    end

    always_comb begin
        mcause_image = '0;
        mcause_image[`RV32_XLEN-1] = mcause_interrupt;
        mcause_image[`RV32_MCAUSE_CODE_W-1:0] = mcause_code;
    end

    always_comb begin
        case (csr)
            CSR_MSTATUS:   read_value = mstatus_image;
            CSR_MISA:      read_value = `RV32_MISA_VALUE;
            CSR_MIE:       read_value = irq_image(mie_bits);
            CSR_MTVEC:     read_value = {mtvec_base, 1'b0, mtvec_mode};
            CSR_MSCRATCH:  read_value = mscratch;
            CSR_MEPC:      read_value = {mepc_word, 2'b00};
            CSR_MCAUSE:    read_value = mcause_image;
            CSR_MTVAL:     read_value = mtval;
            CSR_MIP:       read_value = irq_image(mip_bits);
            CSR_MCYCLE,
            CSR_CYCLE,
            CSR_TIME:      read_value = cycle_count[`RV32_XLEN-1:0];
            CSR_MCYCLEH,
            CSR_CYCLEH,
            CSR_TIMEH:     read_value = cycle_count[`RV32_COUNTER_W-1:`RV32_XLEN];
            CSR_MINSTRET,
            CSR_INSTRET:   read_value = instret_count[`RV32_XLEN-1:0];
            CSR_MINSTRETH,
            CSR_INSTRETH:  read_value = instret_count[`RV32_COUNTER_W-1:`RV32_XLEN];
            CSR_MVENDORID,
            CSR_MARCHID,
            CSR_MIMPID,
            CSR_MHARTID:   read_value = '0;
            default:       read_value = '0;
        endcase
    end

    assign operand = (src == CSR_SRC_REG) ? rs1_value : imm_value;

    always_comb begin
        case (write_op)
            CSR_OP_WRITE: new_value = operand;
            CSR_OP_SET:   new_value = read_value | operand;
            CSR_OP_CLEAR: new_value = read_value & ~operand;
            default:      new_value = read_value;
        endcase
    end

    // Stalled or flushed instructions must not commit.
    assign write_strobe = write && !stall && !flush;

endmodule

// ==== design/rv32_csr_addr_pkg.sv ====
`include "rv32_csr_params.svh"

package rv32_csr_addr_pkg;

    typedef logic [`RV32_CSR_ADDR_W-1:0] csr_addr_t;

    // Machine trap setup and handling.
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MTVAL     = 12'h343;
    localparam csr_addr_t CSR_MIP       = 12'h344;

    // Machine counters.
    localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
    localparam csr_addr_t CSR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t CSR_MINSTRETH = 12'hB82;

    // User counters, time aliases cycle.
    localparam csr_addr_t CSR_CYCLE     = 12'hC00;
    localparam csr_addr_t CSR_TIME      = 12'hC01;
    localparam csr_addr_t CSR_INSTRET   = 12'hC02;
    localparam csr_addr_t CSR_CYCLEH    = 12'hC80;
    localparam csr_addr_t CSR_TIMEH     = 12'hC81;
    localparam csr_addr_t CSR_INSTRETH  = 12'hC82;

    // Machine information registers.
    localparam csr_addr_t CSR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_MIMPID    = 12'hF13;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;

endpackage

// ==== design/rv32_csr_counters.sv ====
`timescale 1ns/1ns

module rv32_csr_counters
    import rv32_csr_ops_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     instr_retired,
    input  logic     writeback_flush,
    output counter_t cycle_count,
    output counter_t instret_count
);

    logic retire_valid;

    // A flushed instruction never retires.
    assign retire_valid = instr_retired && !writeback_flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instret_count <= '0;
        end else if (retire_valid) begin
            instret_count <= instret_count + 1'b1;
        end
    end

endmodule

// ==== design/rv32_csr_ops_pkg.sv ====
`include "rv32_csr_params.svh"

package rv32_csr_ops_pkg;

    typedef logic [`RV32_XLEN-1:0]      xlen_t;
    typedef logic [`RV32_COUNTER_W-1:0] counter_t;

    // Code 3 is left undefined; the access unit treats it as no change.
    typedef enum logic [1:0] {
        CSR_OP_WRITE = 2'b00,
        CSR_OP_SET   = 2'b01,
        CSR_OP_CLEAR = 2'b10
    } csr_write_op_e;

    typedef enum logic {
        CSR_SRC_IMM = 1'b0,
        CSR_SRC_REG = 1'b1
    } csr_src_e;

endpackage

// ==== design/rv32_csr_trap_regs.sv ====
`timescale 1ns/1ns

`include "rv32_csr_params.svh"

module rv32_csr_trap_regs
    import rv32_csr_addr_pkg::*, rv32_csr_ops_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           write_strobe,
    input  csr_addr_t                      csr,
    input  xlen_t                          new_value,

    output logic                           mstatus_mie,
    output logic                           mstatus_mpie,
    output logic [2:0]                     mie_bits,
    output logic [2:0]                     mip_bits,
    output logic [`RV32_XLEN-3:0]          mtvec_base,
    output logic                           mtvec_mode,
    output xlen_t                          mscratch,
    output logic [`RV32_XLEN-3:0]          mepc_word,
    output logic                           mcause_interrupt,
    output logic [`RV32_MCAUSE_CODE_W-1:0] mcause_code,
    output xlen_t                          mtval
);

    logic [2:0] irq_field;

    // External, timer, software from high to low.
    assign irq_field = {new_value[`RV32_IRQ_EXT_BIT],
                        new_value[`RV32_IRQ_TIMER_BIT],
                        new_value[`RV32_IRQ_SOFT_BIT]};

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus_mie      <= 1'b0;
            mstatus_mpie     <= 1'b0;
            mie_bits         <= '0;
            mip_bits         <= '0;
            mtvec_base       <= '0;
            mtvec_mode       <= 1'b0;
            mscratch         <= '0;
            mepc_word        <= '0;
            mcause_interrupt <= 1'b0;
            mcause_code      <= '0;
            mtval            <= '0;
        end else if (write_strobe) begin
            case (csr)
                CSR_MSTATUS: begin
                    mstatus_mie  <= new_value[`RV32_MSTATUS_MIE_BIT];
                    mstatus_mpie <= new_value[`RV32_MSTATUS_MPIE_BIT];
                end
                CSR_MIE: begin
                    mie_bits <= irq_field;
                end
                CSR_MIP: begin
                    mip_bits <= irq_field;
                end
                CSR_MTVEC: begin
                    // Bit 1 is reserved, only direct and vectored modes.
                    mtvec_base <= new_value[`RV32_XLEN-1:2];
                    mtvec_mode <= new_value[0];
                end
                CSR_MSCRATCH: begin
                    mscratch <= new_value;
                end
                CSR_MEPC: begin
                    mepc_word <= new_value[`RV32_XLEN-1:2];
                end
                CSR_MCAUSE: begin
                    mcause_interrupt <= new_value[`RV32_XLEN-1];
                    mcause_code      <= new_value[`RV32_MCAUSE_CODE_W-1:0];
                end
                CSR_MTVAL: begin
                    mtval <= new_value;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== design/rv32_csrs.sv ====
`timescale 1ns/1ns

`include "rv32_csr_params.svh"

module rv32_csrs
    import rv32_csr_addr_pkg::*, rv32_csr_ops_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          stall,
    input  logic          flush,
    input  logic          writeback_flush,

    input  logic          read,
    input  logic          write,
    input  csr_write_op_e write_op,
    input  csr_src_e      src,
    input  csr_addr_t     csr,
    input  xlen_t         rs1_value,
    input  xlen_t         imm_value,

    input  logic          instr_retired,

    output xlen_t         read_value,
    output counter_t      cycle
);

    logic                           write_strobe;
    xlen_t                          new_value;
    logic                           mstatus_mie;
    logic                           mstatus_mpie;
    logic [2:0]                     mie_bits;
    logic [2:0]                     mip_bits;
    logic [`RV32_XLEN-3:0]          mtvec_base;
    logic                           mtvec_mode;
    xlen_t                          mscratch;
    logic [`RV32_XLEN-3:0]          mepc_word;
    logic                           mcause_interrupt;
    logic [`RV32_MCAUSE_CODE_W-1:0] mcause_code;
    xlen_t                          mtval;
    counter_t                       cycle_count;
    counter_t                       instret_count;

    // Reads have no side effects, read is only part of the pipeline contract.

    rv32_csr_trap_regs u_trap_regs (
        .clk              (clk),
        .reset            (reset),
        .write_strobe     (write_strobe),
        .csr              (csr),
        .new_value        (new_value),
        .mstatus_mie      (mstatus_mie),
        .mstatus_mpie     (mstatus_mpie),
        .mie_bits         (mie_bits),
        .mip_bits         (mip_bits),
        .mtvec_base       (mtvec_base),
        .mtvec_mode       (mtvec_mode),
        .mscratch         (mscratch),
        .mepc_word        (mepc_word),
        .mcause_interrupt (mcause_interrupt),
        .mcause_code      (mcause_code),
        .mtval            (mtval)
    );

    rv32_csr_counters u_counters (
        .clk             (clk),
        .reset           (reset),
        .instr_retired   (instr_retired),
        .writeback_flush (writeback_flush),
        .cycle_count     (cycle_count),
        .instret_count   (instret_count)
    );

    rv32_csr_access u_access (
        .stall            (stall),
        .flush            (flush),
        .write            (write),
        .write_op         (write_op),
        .src              (src),
        .csr              (csr),
        .rs1_value        (rs1_value),
        .imm_value        (imm_value),
        .mstatus_mie      (mstatus_mie),
        .mstatus_mpie     (mstatus_mpie),
        .mie_bits         (mie_bits),
        .mip_bits         (mip_bits),
        .mtvec_base       (mtvec_base),
        .mtvec_mode       (mtvec_mode),
        .mscratch         (mscratch),
        .mepc_word        (mepc_word),
        .mcause_interrupt (mcause_interrupt),
        .mcause_code      (mcause_code),
        .mtval            (mtval),
        .cycle_count      (cycle_count),
        .instret_count    (instret_count),
        .read_value       (read_value),
        .new_value        (new_value),
        .write_strobe     (write_strobe)
    );

    assign cycle = cycle_count;

endmodule

// ==== include/rv32_csr_params.svh ====
`ifndef RV32_CSR_PARAMS_SVH
`define RV32_CSR_PARAMS_SVH

// Data, address and counter widths.
`define RV32_XLEN        32
`define RV32_CSR_ADDR_W  12
`define RV32_COUNTER_W   64

// MXL of 1 for a 32-bit hart, only the I extension set.
`define RV32_MISA_VALUE  32'h4000_0100

// Field positions in mstatus.
`define RV32_MSTATUS_MIE_BIT   3
`define RV32_MSTATUS_MPIE_BIT  7
`define RV32_MSTATUS_MPP_LO    11
`define RV32_MSTATUS_MPP_HI    12

// Software, timer and external bits, shared by mie and mip.
`define RV32_IRQ_SOFT_BIT   3
`define RV32_IRQ_TIMER_BIT  7
`define RV32_IRQ_EXT_BIT    11

// Interrupt flag and exception code in mcause.
`define RV32_MCAUSE_CODE_W  4

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the CSR testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_rv32_csrs -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

sim_output=$(./obj_dir/Vtb_rv32_csrs)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status."
    exit 1
fi

if echo "$sim_output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// ==== verif/rv32_csr_testdata.txt ====
// kind csr op src rs1 imm stall_flush expected, all hex
// kind 0 write, 1 read check, 2 retire, 3 counter check; stall_flush is {stall, flush}
1 300 0 0 00000000 00000000 0 00001800
1 301 0 0 00000000 00000000 0 40000100
1 304 0 0 00000000 00000000 0 00000000
1 342 0 0 00000000 00000000 0 00000000
1 F14 0 0 00000000 00000000 0 00000000
0 300 0 1 FFFFFFFF 00000000 0 00000000
1 300 0 0 00000000 00000000 0 00001888
0 304 0 1 FFFFFFFF 00000000 0 00000000
1 304 0 0 00000000 00000000 0 00000888
0 305 0 1 FFFFFFFF 00000000 0 00000000
1 305 0 0 00000000 00000000 0 FFFFFFFD
0 341 0 1 FFFFFFFF 00000000 0 00000000
1 341 0 0 00000000 00000000 0 FFFFFFFC
0 342 0 1 FFFFFFFF 00000000 0 00000000
1 342 0 0 00000000 00000000 0 8000000F
0 343 0 1 FFFFFFFF 00000000 0 00000000
1 343 0 0 00000000 00000000 0 FFFFFFFF
0 340 0 0 00000000 A5A5F00F 0 00000000
1 340 0 0 00000000 00000000 0 A5A5F00F
0 340 1 0 00000000 00000FF0 0 00000000
1 340 0 0 00000000 00000000 0 A5A5FFFF
0 340 2 1 0000FF00 00000000 0 00000000
1 340 0 0 00000000 00000000 0 A5A500FF
0 340 3 1 FFFFFFFF FFFFFFFF 0 00000000
1 340 0 0 00000000 00000000 0 A5A500FF
0 340 0 1 12345678 00000000 2 00000000
1 340 0 0 00000000 00000000 0 A5A500FF
0 340 0 1 12345678 00000000 1 00000000
1 340 0 0 00000000 00000000 0 A5A500FF
0 301 0 1 FFFFFFFF 00000000 0 00000000
1 301 0 0 00000000 00000000 0 40000100
0 7C0 0 1 FFFFFFFF 00000000 0 00000000
1 7C0 0 0 00000000 00000000 0 00000000
0 C00 0 1 00000000 00000000 0 00000000
3 C00 0 0 00000000 00000000 0 00000000
3 C01 0 0 00000000 00000000 0 00000000
3 C81 0 0 00000000 00000000 0 00000000
3 B00 0 0 00000000 00000000 0 00000000
2 000 0 0 00000000 00000000 0 00000000
2 000 0 0 00000000 00000000 1 00000000
2 000 0 0 00000000 00000000 0 00000000
3 C02 0 0 00000000 00000000 0 00000000
3 B02 0 0 00000000 00000000 0 00000000
3 C82 0 0 00000000 00000000 0 00000000

// ==== verif/tb_rv32_csrs.sv ====
`timescale 1ns/1ns

module tb_rv32_csrs
    import rv32_csr_addr_pkg::*, rv32_csr_ops_pkg::*;
;

    localparam int    MAX_STEPS  = 64;
    localparam int    STEP_WORDS = 8;
    localparam string DATA_FILE  = "verif/rv32_csr_testdata.txt";

    logic          clk;
    logic          reset;
    logic          stall;
    logic          flush;
    logic          writeback_flush;
    logic          read;
    logic          write;
    csr_write_op_e write_op;
    csr_src_e      src;
    csr_addr_t     csr;
    xlen_t         rs1_value;
    xlen_t         imm_value;
    logic          instr_retired;
    xlen_t         read_value;
    counter_t      cycle;

    // Eight words per step, kind first.
    logic [31:0] step_mem [0:MAX_STEPS*STEP_WORDS-1];

    int       step_count;
    int       cycle_limit = 0;
    int       run_cycles = 0;
    int       error_count;
    int       check_count;
    counter_t model_cycles;
    counter_t model_instret;

    rv32_csrs u_dut (
        .clk             (clk),
        .reset           (reset),
        .stall           (stall),
        .flush           (flush),
        .writeback_flush (writeback_flush),
        .read            (read),
        .write           (write),
        .write_op        (write_op),
        .src             (src),
        .csr             (csr),
        .rs1_value       (rs1_value),
        .imm_value       (imm_value),
        .instr_retired   (instr_retired),
        .read_value      (read_value),
        .cycle           (cycle)
    );

    always #4 clk = ~clk;

    // Clocks seen since reset was released.
    always @(posedge clk) begin
        if (reset) begin
            model_cycles <= '0;
        end else begin
            model_cycles <= model_cycles + 64'd1;
        end
    end

    always @(posedge clk) begin
        run_cycles = run_cycles + 1;
        if (cycle_limit > 0 && run_cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, checks: %0d, errors: %0d",
                     run_cycles, check_count, error_count);
            $display("sim failed");
            $finish;
        end
    end

    task automatic compare_value(input string name, input counter_t expected,
                                 input counter_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Counter halves by CSR number, time aliases cycle.
    function automatic xlen_t counter_expect(input csr_addr_t addr);
        case (addr)
            CSR_CYCLE, CSR_TIME, CSR_MCYCLE:     return model_cycles[31:0];
            CSR_CYCLEH, CSR_TIMEH, CSR_MCYCLEH:  return model_cycles[63:32];
            CSR_INSTRET, CSR_MINSTRET:           return model_instret[31:0];
            CSR_INSTRETH, CSR_MINSTRETH:         return model_instret[63:32];
            default:                             return '0;
        endcase
    endfunction

    task automatic run_step(input int index);
        logic [31:0] kind;
        logic [31:0] flags;
        logic [31:0] expected;
        string       name;
        int          base;
        base            = index * STEP_WORDS;
        kind            = step_mem[base];
        flags           = step_mem[base + 6];
        expected        = step_mem[base + 7];
        csr             = step_mem[base + 1][11:0];
        write_op        = csr_write_op_e'(step_mem[base + 2][1:0]);
        src             = csr_src_e'(step_mem[base + 3][0]);
        rs1_value       = step_mem[base + 4];
        imm_value       = step_mem[base + 5];
        write           = (kind == 32'd0);
        read            = (kind == 32'd1) || (kind == 32'd3);
        stall           = (kind == 32'd0) && flags[1];
        flush           = (kind == 32'd0) && flags[0];
        instr_retired   = (kind == 32'd2);
        writeback_flush = (kind == 32'd2) && flags[0];
        name            = $sformatf("step %0d csr %03h", index, csr);
        if (kind == 32'd2 && !flags[0]) begin
            model_instret = model_instret + 64'd1;
        end
        // Mid-cycle, read_value has settled.
        #4;
        case (kind)
            32'd0, 32'd2: begin
            end
            32'd1: begin
                compare_value(name, {32'd0, expected}, {32'd0, read_value});
            end
            32'd3: begin
                compare_value(name, {32'd0, counter_expect(csr)}, {32'd0, read_value});
                compare_value({name, " cycle port"}, model_cycles, cycle);
            end
            default: begin
                error_count++;
                $display("Step %0d has an unknown kind %0h.", index, kind);
            end
        endcase
        @(posedge clk);
        #1;
    endtask

    task automatic run_test();
        $readmemh(DATA_FILE, step_mem);
        while (step_count < MAX_STEPS && step_mem[step_count * STEP_WORDS] !== 32'hFFFF_FFFF) begin
            step_count++;
        end
        if (step_count == 0) begin
            error_count++;
            $display("The test data file holds no steps.");
        end
        cycle_limit = 4 * step_count + 50;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < step_count; i++) begin
            run_step(i);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    initial begin
        int fd;
        clk             = 1'b0;
        reset           = 1'b1;
        stall           = 1'b0;
        flush           = 1'b0;
        writeback_flush = 1'b0;
        read            = 1'b0;
        write           = 1'b0;
        write_op        = CSR_OP_WRITE;
        src             = CSR_SRC_IMM;
        csr             = '0;
        rs1_value       = '0;
        imm_value       = '0;
        instr_retired   = 1'b0;
        step_count      = 0;
        error_count     = 0;
        check_count     = 0;
        model_instret   = '0;
        // All ones in the kind word marks the end of the steps.
        for (int i = 0; i < MAX_STEPS * STEP_WORDS; i++) begin
            step_mem[i] = '1;
        end
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the test data file %s.", DATA_FILE);
            $display("sim failed");
            $finish;
        end else begin
            $fclose(fd);
            run_test();
        end
    end

endmodule

// ==== verilog.f ====
+incdir+include
design/rv32_csr_addr_pkg.sv
design/rv32_csr_ops_pkg.sv
design/rv32_csr_trap_regs.sv
design/rv32_csr_counters.sv
design/rv32_csr_access.sv
design/rv32_csrs.sv
verif/tb_rv32_csrs.sv
